// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= rsa_tb
FLIST      ?= rsa_core.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/rsa_core_sva.sv ====
`timescale 1ns/10ps

module rsa_core_sva (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  logic                 i_finished,
	input  rsa_pkg::core_state_t i_state,
	input  logic                 i_mont_start,
	input  rsa_pkg::step_state_t i_mul_state,
	input  rsa_pkg::step_state_t i_sq_state
);
	import rsa_pkg::*;

	// done pulse is a single cycle
	a_fin_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_finished |=> !i_finished)
		else $error("o_finished stayed high for more than one cycle");

	// the shared strobe must find both multipliers idle so both take it
	a_mont_together: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_mont_start |-> ((i_mul_state == ST_IDLE) && (i_sq_state == ST_IDLE)))
		else $error("u_mont_mul and u_mont_sq did not both accept the start strobe");

	a_fin_after_done: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_finished |-> ($past(i_state) == CORE_DONE))
		else $error("o_finished raised without passing through CORE_DONE");

	// idle is left only on a start strobe
	a_idle_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_state == CORE_IDLE && !i_start) |=> (i_state == CORE_IDLE))
		else $error("core left CORE_IDLE without i_start");

endmodule

bind rsa_core rsa_core_sva u_sva (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_start      (i_start),
	.i_finished   (o_finished),
	.i_state      (state_r),
	.i_mont_start (mont_start_r),
	.i_mul_state  (u_mont_mul.state_r),
	.i_sq_state   (u_mont_sq.state_r)
);

// ==== dv/rsa_tb.sv ====
`timescale 1ns/10ps

module rsa_tb;
	import rsa_pkg::*;

	localparam int CYCLES_PER_TEST = 70000;
	localparam int BUSY_STROBE_DLY = 6;

	logic     i_clk;
	logic     i_rst;
	logic     i_start;
	rsa_req_t i_req;
	word_t    o_result;
	logic     o_finished;

	word_t    tr_a[$];
	word_t    tr_d[$];
	word_t    tr_n[$];
	word_t    tr_exp[$];
	int       tr_gap[$];

	int       n_tests;
	int       pass_cnt;
	int       fail_cnt;
	int       err_cnt;
	int       pulse_total;
	longint   cycle_cnt;
	longint   cycle_limit;
	word_t    held;

	rsa_core i_dut (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (i_start),
		.i_req      (i_req),
		.o_result   (o_result),
		.o_finished (o_finished)
	);

	initial i_clk = 1'b0;
	always #4 i_clk = ~i_clk;

	// every done pulse over the whole run
	always @(negedge i_clk) begin
		if (i_rst && o_finished) begin
			pulse_total++;
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the core seems to hang", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic read_trace();
		int    fd;
		int    cnt;
		int    gap;
		string line;
		word_t a;
		word_t d;
		word_t n;
		word_t e;
		fd = $fopen("dv/rsa_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file dv/rsa_trace.txt");
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// skip comments and blank lines
			if (line.len() > 1 && line[0] != 8'h23) begin
				cnt = $sscanf(line, "%h %h %h %h %d", a, d, n, e, gap);
				if (cnt == 5) begin
					tr_a.push_back(a);
					tr_d.push_back(d);
					tr_n.push_back(n);
					tr_exp.push_back(e);
					tr_gap.push_back(gap);
				end
			end
		end
		$fclose(fd);
	endtask

	// no pulse and an unchanged result while nothing completes
	task automatic check_quiet();
		assert (!o_finished) else begin
			$display("unexpected o_finished pulse at %0t", $time);
			err_cnt++;
		end
		assert (o_result == held) else begin
			$display("ERR %0t o_result changed before o_finished: expected %h got %h",
				$time, held, o_result);
			err_cnt++;
		end
	endtask

	task automatic run_test(input int idx);
		int extra;
		int errs_before;
		errs_before = err_cnt;
		extra = 0;
		// a zero gap stays back to back
		if (tr_gap[idx] > 0) begin
			extra = int'($urandom % 4);
		end
		repeat (tr_gap[idx] + extra) begin
			@(negedge i_clk);
			check_quiet();
		end
		@(posedge i_clk);
		i_req.a <= tr_a[idx];
		i_req.d <= tr_d[idx];
		i_req.n <= tr_n[idx];
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
		repeat (BUSY_STROBE_DLY) @(posedge i_clk);
		// a second strobe while busy must be ignored
		i_start <= 1'b1;
		@(posedge i_clk);
		i_start <= 1'b0;
		do begin
			@(negedge i_clk);
			if (!o_finished) begin
				check_quiet();
			end
		end while (!o_finished);
		assert (o_result == tr_exp[idx]) else begin
			$display("ERR %0t test %0d wrong result: expected %h got %h",
				$time, idx, tr_exp[idx], o_result);
			err_cnt++;
		end
		held = o_result;
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %0d passed at %0t", idx, $time);
		end else begin
			fail_cnt++;
			$display("test %0d failed at %0t", idx, $time);
		end
	endtask

	initial begin
		i_rst       = 1'b0;
		i_start     = 1'b0;
		i_req       = '0;
		n_tests     = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		err_cnt     = 0;
		pulse_total = 0;
		cycle_cnt   = 0;
		cycle_limit = 0;
		held        = '0;
		void'($urandom(19557));

		read_trace();
		n_tests = tr_a.size();
		if (n_tests == 0) begin
			$display("the trace holds no test vectors");
			err_cnt++;
		end
		cycle_limit = longint'(n_tests) * CYCLES_PER_TEST + 1000;

		repeat (4) @(posedge i_clk);
		i_rst <= 1'b1;

		// outputs after reset, before any start
		@(negedge i_clk);
		assert (!o_finished) else begin
			$display("o_finished is high after reset");
			err_cnt++;
		end
		assert (o_result == '0) else begin
			$display("ERR %0t o_result after reset: expected 0 got %h", $time, o_result);
			err_cnt++;
		end

		for (int i = 0; i < n_tests; i++) begin
			run_test(i);
		end

		// the busy strobes must not have produced late pulses
		repeat (300) begin
			@(negedge i_clk);
			check_quiet();
		end
		assert (pulse_total == n_tests) else begin
			$display("expected %0d o_finished pulses but saw %0d", n_tests, pulse_total);
			err_cnt++;
		end

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== dv/rsa_trace.txt ====
# columns: a d n expected gap, all hex except the gap in decimal idle cycles
# expected = a^d mod n, p = 2^255-19, q = 2^256-189
3 5 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed f3 3
1c9e4a7b3f20d58e6a1b9c47e05d3f8294b7a61c0e8d5f237ab94c61d2f08e35 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 1 1
1c9e4a7b3f20d58e6a1b9c47e05d3f8294b7a61c0e8d5f237ab94c61d2f08e35 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 1c9e4a7b3f20d58e6a1b9c47e05d3f8294b7a61c0e8d5f237ab94c61d2f08e35 0
0 6b2f9d04a57e1c38f94d60ab2c8e71530fd4a96eb3715c28e6a0d94f17c3b85d 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 0 2
1 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 1 1
7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0
6b2f9d04a57e1c38f94d60ab2c8e71530fd4a96eb3715c28e6a0d94f17c3b85d 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 6b2f9d04a57e1c38f94d60ab2c8e71530fd4a96eb3715c28e6a0d94f17c3b85d 4
1c9e4a7b3f20d58e6a1b9c47e05d3f8294b7a61c0e8d5f237ab94c61d2f08e35 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 1 0
4 3ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff6 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 1 2
2 3ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff6 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec 0
100000000000000000000000000000000 2 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 26 1
100000000000000000000000000000000000000000000000000 2 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 26000000000000000000000000000000000000 0
10000000000000000000000000 3 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed 2600000000000 2
10001 3 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 1000300030001 1
d3a5710c8e2b94f61a7c05d9e4b3682f597ec1a03d86f2b4c05a9e718b24d63f ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff43 d3a5710c8e2b94f61a7c05d9e4b3682f597ec1a03d86f2b4c05a9e718b24d63f 0
2 c d 1 3
5 3 21 1a 0

// ==== hdl/rsa_config.svh ====
`ifndef RSA_CONFIG_SVH
`define RSA_CONFIG_SVH

// operand width of the RSA datapath in bits
// the bit-serial steps assume an even width
`define RSA_WIDTH 256

// width of every step and bit counter
// must hold RSA_WIDTH - 1
`define RSA_CNT_WIDTH 8

`endif

// ==== hdl/rsa_core.sv ====
`timescale 1ns/10ps
`include "rsa_config.svh"

module rsa_core (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  rsa_pkg::rsa_req_t i_req,
	output rsa_pkg::word_t    o_result,
	output logic              o_finished
);
	import rsa_pkg::*;

	core_state_t state_r, state_w;
	step_cnt_t   bit_r, bit_w;
	word_t       result_r, result_w;
	word_t       power_r, power_w;
	word_t       out_r, out_w;
	logic        fin_r, fin_w;
	logic        mont_start_r, mont_start_w;

	logic        prep_start;
	word_t       prep_result;
	logic        prep_finished;
	mont_op_t    mul_op;
	mont_op_t    sq_op;
	word_t       mul_result;
	word_t       sq_result;
	logic        sq_finished;
	logic        last_bit;

	assign last_bit   = (bit_r == step_cnt_t'(`RSA_WIDTH - 1));
	assign o_result   = out_r;
	assign o_finished = fin_r;

	// prep samples the request on the same edge as the core
	assign prep_start = (state_r == CORE_IDLE) && i_start;

	rsa_prep u_prep (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (prep_start),
		.i_a        (i_req.a),
		.i_n        (i_req.n),
		.o_result   (prep_result),
		.o_finished (prep_finished)
	);

	// result times power, and power squared
	assign mul_op.a = result_r;
	assign mul_op.b = power_r;
	assign sq_op.a  = power_r;
	assign sq_op.b  = power_r;

	// equal latency, so only the square's pulse is watched
	rsa_mont u_mont_mul (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (mont_start_r),
		.i_op       (mul_op),
		.i_n        (i_req.n),
		.o_result   (mul_result),
		.o_finished ()
	);

	rsa_mont u_mont_sq (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (mont_start_r),
		.i_op       (sq_op),
		.i_n        (i_req.n),
		.o_result   (sq_result),
		.o_finished (sq_finished)
	);

	always_comb begin
		state_w      = state_r;
		bit_w        = bit_r;
		result_w     = result_r;
		power_w      = power_r;
		out_w        = out_r;
		mont_start_w = 1'b0;
		fin_w        = 1'b0;
		case (state_r)
			CORE_IDLE: begin
				bit_w = '0;
				if (i_start) begin
					result_w = word_t'(1);
					state_w  = CORE_PREP;
				end
			end
			CORE_PREP: begin
				// a in the Montgomery domain is the first power
				if (prep_finished) begin
					power_w      = prep_result;
					mont_start_w = 1'b1;
					state_w      = CORE_MONT;
				end
			end
			CORE_MONT: begin
				if (sq_finished) begin
					power_w = sq_result;
					// product kept only for set bits of d
					if (i_req.d[bit_r]) begin
						result_w = mul_result;
					end
					if (last_bit) begin
						state_w = CORE_DONE;
					end else begin
						bit_w        = step_cnt_t'(bit_r + 1'b1);
						mont_start_w = 1'b1;
					end
				end
			end
			CORE_DONE: begin
				out_w   = result_r;
				fin_w   = 1'b1;
				state_w = CORE_IDLE;
			end
			default: state_w = CORE_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r      <= CORE_IDLE;
			bit_r        <= '0;
			mont_start_r <= 1'b0;
			fin_r        <= 1'b0;
			out_r        <= '0;
		end else begin
			state_r      <= state_w;
			bit_r        <= bit_w;
			mont_start_r <= mont_start_w;
			fin_r        <= fin_w;
			out_r        <= out_w;
		end
	end

	always_ff @(posedge i_clk) begin
		result_r <= result_w;
		power_r  <= power_w;
	end

endmodule

// ==== hdl/rsa_mont.sv ====
`timescale 1ns/10ps
`include "rsa_config.svh"

module rsa_mont (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  rsa_pkg::mont_op_t i_op,
	input  rsa_pkg::word_t    i_n,
	output rsa_pkg::word_t    o_result,
	output logic              o_finished
);
	import rsa_pkg::*;

	step_state_t state_r, state_w;
	step_cnt_t   cnt_r, cnt_w;
	word_t       a_r, a_w;
	wide_t       sum_r, sum_w;
	logic        fin_r, fin_w;
	wide_t       n_wide;
	wide_t       b_wide;
	wide_t       add_b;
	wide_t       add_n;
	wide_t       half;
	logic        last_step;

	assign last_step  = (cnt_r == step_cnt_t'(`RSA_WIDTH - 1));
	assign n_wide     = wide_t'(i_n);
	assign b_wide     = wide_t'(i_op.b);
	assign o_result   = sum_r[`RSA_WIDTH-1:0];
	assign o_finished = fin_r;

	always_comb begin
		state_w = state_r;
		case (state_r)
			ST_IDLE: if (i_start) state_w = ST_CALC;
			ST_CALC: if (last_step) state_w = ST_DONE;
			ST_DONE: state_w = ST_IDLE;
			default: state_w = ST_IDLE;
		endcase
	end

	always_comb begin
		if (state_r == ST_CALC) begin
			cnt_w = step_cnt_t'(cnt_r + 1'b1);
		end else begin
			cnt_w = '0;
		end
	end

	// multiplier bits, consumed from the low end
	always_comb begin
		a_w = a_r;
		case (state_r)
			ST_IDLE: if (i_start) a_w = i_op.a;
			ST_CALC: a_w = a_r >> 1;
			default: a_w = a_r;
		endcase
	end

	// sum stays below 2n, so sum + b + n fits in the guard bits
	// b and n are read live, the caller keeps them stable while busy
	always_comb begin
		add_b = a_r[0] ? sum_r + b_wide : sum_r;
		add_n = add_b[0] ? add_b + n_wide : add_b;
		half  = add_n >> 1;
		sum_w = sum_r;
		case (state_r)
			ST_IDLE: if (i_start) sum_w = '0;
			ST_CALC: begin
				// single correction on the final step brings it below n
				if (last_step && (half >= n_wide)) begin
					sum_w = half - n_wide;
				end else begin
					sum_w = half;
				end
			end
			default: sum_w = sum_r;
		endcase
	end

	assign fin_w = (state_r == ST_DONE);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r <= ST_IDLE;
			cnt_r   <= '0;
			fin_r   <= 1'b0;
		end else begin
			state_r <= state_w;
			cnt_r   <= cnt_w;
			fin_r   <= fin_w;
		end
	end

	always_ff @(posedge i_clk) begin
		a_r   <= a_w;
		sum_r <= sum_w;
	end

endmodule

// ==== hdl/rsa_pkg.sv ====
`include "rsa_config.svh"

package rsa_pkg;

	// one operand, modulus or result
	typedef logic [`RSA_WIDTH-1:0] word_t;

	// partial sums need two guard bits above the operand
	typedef logic [`RSA_WIDTH+1:0] wide_t;

	// step index inside prep and mont, bit index of d in the core
	typedef logic [`RSA_CNT_WIDTH-1:0] step_cnt_t;

	// pacing of the bit-serial units
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_CALC = 2'd1,
		ST_DONE = 2'd2
	} step_state_t;

	// top level sequencing
	typedef enum logic [1:0] {
		CORE_IDLE = 2'd0,
		CORE_PREP = 2'd1,
		CORE_MONT = 2'd2,
		CORE_DONE = 2'd3
	} core_state_t;

	// one decryption request, held by the caller for the whole run
	typedef struct packed {
		word_t a;
		word_t d;
		word_t n;
	} rsa_req_t;

	// operand pair of one Montgomery product
	typedef struct packed {
		word_t a;
		word_t b;
	} mont_op_t;

endpackage

// ==== hdl/rsa_prep.sv ====
`timescale 1ns/10ps
`include "rsa_config.svh"

module rsa_prep (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_start,
	input  rsa_pkg::word_t i_a,
	input  rsa_pkg::word_t i_n,
	output rsa_pkg::word_t o_result,
	output logic           o_finished
);
	import rsa_pkg::*;

	step_state_t state_r, state_w;
	step_cnt_t   cnt_r, cnt_w;
	word_t       a_r, a_w;
	logic        fin_r, fin_w;
	wide_t       dbl;
	wide_t       n_wide;
	logic        last_step;

	assign last_step  = (cnt_r == step_cnt_t'(`RSA_WIDTH - 1));
	assign n_wide     = wide_t'(i_n);
	assign o_result   = a_r;
	assign o_finished = fin_r;

	always_comb begin
		state_w = state_r;
		case (state_r)
			ST_IDLE: if (i_start) state_w = ST_CALC;
			ST_CALC: if (last_step) state_w = ST_DONE;
			ST_DONE: state_w = ST_IDLE;
			default: state_w = ST_IDLE;
		endcase
	end

	// counts the doubling steps, parked at zero outside CALC
	always_comb begin
		if (state_r == ST_CALC) begin
			cnt_w = step_cnt_t'(cnt_r + 1'b1);
		end else begin
			cnt_w = '0;
		end
	end

	// one modular doubling per step, a < n keeps 2a below 2n
	always_comb begin
		dbl = {1'b0, a_r, 1'b0};
		a_w = a_r;
		case (state_r)
			ST_IDLE: if (i_start) a_w = i_a;
			ST_CALC: begin
				if (dbl >= n_wide) begin
					a_w = word_t'(dbl - n_wide);
				end else begin
					a_w = word_t'(dbl);
				end
			end
			default: a_w = a_r;
		endcase
	end

	// pulse one cycle after the last step
	assign fin_w = (state_r == ST_DONE);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r <= ST_IDLE;
			cnt_r   <= '0;
			fin_r   <= 1'b0;
		end else begin
			state_r <= state_w;
			cnt_r   <= cnt_w;
			fin_r   <= fin_w;
		end
	end

	always_ff @(posedge i_clk) begin
		a_r <= a_w;
	end

endmodule

// ==== rsa_core.f ====
+incdir+hdl
hdl/rsa_pkg.sv
hdl/rsa_prep.sv
hdl/rsa_mont.sv
hdl/rsa_core.sv
dv/rsa_core_sva.sv
dv/rsa_tb.sv
